// File: files.f
+incdir+design
design/io_map_pkg.sv
design/ems_pkg.sv
design/io_decoder.sv
design/ems_mapper.sv
design/io_latches.sv
design/readback_mux.sv
design/peripherals_top.sv
bench/peripherals_properties.sv
bench/tb_peripherals.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the peripheral block testbench with Verilator

cd "$(dirname "$0")" || exit 1

log_file=sim.log

verilator --binary --timing --assert -f files.f --top-module tb_peripherals -o tb_peripherals
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_peripherals +verilator+error+limit+1000 > "$log_file" 2>&1
run_status=$?
cat "$log_file"
if [ $run_status -ne 0 ]; then
    echo "Simulation run exited with status $run_status"
    exit 1
fi

if grep -q -x "Simulation completed successfully" "$log_file"; then
    exit 0
fi

echo "Pass message not found in $log_file"
exit 1

// File: bench/tb_peripherals.sv
// Testbench for the XT peripheral block
// Drives I/O and memory cycles and checks decode, EMS mapping,
// latches and read-back against reference models

`default_nettype none
`timescale 1ns/1ps

`include "peripherals_consts.svh"

module tb_peripherals;

    import io_map_pkg::*;
    import ems_pkg::*;

    localparam int        TEST_COUNT = 6;
    localparam bus_addr_t EMS_ADDR   = 20'(`PERIPH_EMS_PORT_BASE);
    localparam bus_addr_t LPT_ADDR   = 20'(`PERIPH_LPT_PORT);
    localparam bus_addr_t NMI_ADDR   = 20'(`PERIPH_NMI_PORT_BASE);

    logic             clock;
    logic             reset;
    bus_addr_t        address;
    bus_data_t        data;
    logic             address_enable_n;
    logic             io_read_n;
    logic             io_write_n;
    logic             ems_enabled;
    logic             tandy_video;
    ems_frame_sel_t   ems_frame;
    chip_select_n_t   chip_select_n;
    logic [3:0]       ems_bank_hit;
    ems_entry_t [3:0] ems_map;
    bus_data_t        data_bus_out;
    logic             from_chipset;

    // Reference state
    ems_entry_t [3:0] ems_model;
    bus_data_t        lpt_model;
    bus_data_t        nmi_model;

    integer seed = 32'h40b5addf;
    int     error_count = 0;
    int     check_count = 0;
    int     failed_tests = 0;

    peripherals_top peripherals_top_i (
        .clock                       (clock),
        .reset                       (reset),
        .address_i                   (address),
        .data_i                      (data),
        .address_enable_n_i          (address_enable_n),
        .io_read_n_i                 (io_read_n),
        .io_write_n_i                (io_write_n),
        .ems_enabled_i               (ems_enabled),
        .tandy_video_i               (tandy_video),
        .ems_frame_i                 (ems_frame),
        .chip_select_n_o             (chip_select_n),
        .ems_bank_hit_o              (ems_bank_hit),
        .ems_map_o                   (ems_map),
        .data_bus_out_o              (data_bus_out),
        .data_bus_out_from_chipset_o (from_chipset)
    );

    bind peripherals_top peripherals_properties peripherals_properties_i (
        .clock           (clock),
        .reset           (reset),
        .chip_select_n_i (chip_select_n_o),
        .io_read_n_i     (io_read_n_i),
        .io_write_n_i    (io_write_n_i),
        .read_valid_i    (data_bus_out_from_chipset_o)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    initial begin
        repeat (2000 * TEST_COUNT) @(posedge clock);
        $display("Watchdog expired after %0d cycles, tests did not finish", 2000 * TEST_COUNT);
        $display("Simulation failed");
        $finish;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        check_count++;
        assert (got === expected) else begin
            $display("[FAIL] %s got 0x%0h expected 0x%0h at %0t", name, got, expected, $time);
            error_count++;
        end
    endtask

    function automatic chip_select_n_t expected_selects(input bus_addr_t addr,
                                                        input logic aen_n, input logic rd_n);
        chip_select_n_t sel;
        sel = 5'b11111;
        for (int k = 0; k < 5; k++) begin
            if (!aen_n && !rd_n && addr[9:8] == 2'b00 && addr[7:5] == 3'(k)) begin
                sel[k] = 1'b0;
            end
        end
        return sel;
    endfunction

    function automatic ems_entry_t next_entry(input ems_entry_t current, input bus_data_t value);
        ems_entry_t result;
        result = current;
        if (value == 8'hFF) begin
            result.enable = 1'b0;
            result.page   = 7'h7F;
        end else if (value < 8'h80) begin
            result.enable = 1'b1;
            result.page   = value[6:0];
        end
        return result;
    endfunction

    function automatic bus_data_t expected_ems_read(input ems_entry_t entry);
        return entry.enable ? {1'b0, entry.page} : 8'hFF;
    endfunction

    function automatic logic [3:0] frame_top(input ems_frame_sel_t frame);
        case (frame)
            2'd0:    return `PERIPH_EMS_FRAME_A;
            2'd1:    return `PERIPH_EMS_FRAME_C;
            default: return `PERIPH_EMS_FRAME_D;
        endcase
    endfunction

    function automatic logic [3:0] expected_bank_hits(input bus_addr_t addr,
                                                      input ems_frame_sel_t frame,
                                                      input logic strobe);
        logic [3:0] hits;
        hits = 4'b0000;
        for (int k = 0; k < 4; k++) begin
            if (!strobe && ems_model[k].enable && addr[19:16] == frame_top(frame)
                    && addr[15:14] == 2'(k)) begin
                hits[k] = 1'b1;
            end
        end
        return hits;
    endfunction

    task automatic io_write(input bus_addr_t addr, input bus_data_t value);
        @(posedge clock);
        address          <= addr;
        data             <= value;
        address_enable_n <= 1'b0;
        io_write_n       <= 1'b0;
        @(posedge clock);
        io_write_n <= 1'b1;
    endtask

    task automatic read_check(input bus_addr_t addr, input string name,
                              input bus_data_t expected, input logic expected_valid);
        @(posedge clock);
        address          <= addr;
        address_enable_n <= 1'b0;
        io_read_n        <= 1'b0;
        @(posedge clock);
        io_read_n <= 1'b1;
        @(negedge clock);
        check_value(name, 32'(data_bus_out), 32'(expected));
        check_value("data_bus_out_from_chipset_o", 32'(from_chipset), 32'(expected_valid));
    endtask

    // Map register changes one edge after the write is sampled
    task automatic write_ems(input ems_slot_t slot, input bus_data_t value);
        io_write(EMS_ADDR + 20'(slot), value);
        @(negedge clock);
        check_value("ems_map_o before update", 32'(ems_map[slot]), 32'(ems_model[slot]));
        ems_model[slot] = next_entry(ems_model[slot], value);
        @(negedge clock);
        check_value("ems_map_o", 32'(ems_map[slot]), 32'(ems_model[slot]));
        read_check(EMS_ADDR + 20'(slot), "ems data_bus_out_o",
                   expected_ems_read(ems_model[slot]), 1'b1);
    endtask

    task automatic test_decode();
        logic [31:0] r;
        bus_addr_t   addr;
        logic        aen_n;
        logic        rd_n;
        for (int i = 0; i < 240; i++) begin
            r     = $random(seed);
            addr  = r[19:0];
            rd_n  = r[21];
            aen_n = (i >= 200) ? 1'b1 : (r[22] & r[23]);
            if (r[20]) begin
                addr[9:8] = 2'b00;
            end
            @(posedge clock);
            address          <= addr;
            address_enable_n <= aen_n;
            io_read_n        <= (i >= 200) ? 1'b0 : rd_n;
            @(negedge clock);
            check_value("chip_select_n_o", 32'(chip_select_n),
                        32'(expected_selects(addr, aen_n, (i >= 200) ? 1'b0 : rd_n)));
        end
        @(posedge clock);
        io_read_n        <= 1'b1;
        address_enable_n <= 1'b0;
    endtask

    task automatic test_ems_writes();
        for (int k = 0; k < 4; k++) begin
            write_ems(2'(k), 8'h05 + 8'(k));
            write_ems(2'(k), 8'h90);
            write_ems(2'(k), 8'hFF);
            write_ems(2'(k), 8'h90);
        end
    endtask

    task automatic test_bank_hits();
        logic [31:0]    r;
        bus_addr_t      addr;
        ems_frame_sel_t frame;
        logic           strobe;
        write_ems(2'd0, 8'h10);
        write_ems(2'd2, 8'h22);
        for (int i = 0; i < 96; i++) begin
            r      = $random(seed);
            frame  = 2'(i / 8 % 4);
            strobe = r[31];
            addr   = {frame_top(frame), 2'(i % 4), r[13:0]};
            if (i >= 64) begin
                addr = r[19:0];
            end
            @(posedge clock);
            ems_frame <= frame;
            address   <= addr;
            io_read_n <= ~strobe;
            @(negedge clock);
            check_value("ems_bank_hit_o", 32'(ems_bank_hit),
                        32'(expected_bank_hits(addr, frame, strobe)));
        end
        @(posedge clock);
        io_read_n <= 1'b1;
    endtask

    task automatic test_printer();
        logic [31:0] r;
        for (int i = 0; i < 8; i++) begin
            r = $random(seed);
            io_write(LPT_ADDR, r[7:0]);
            lpt_model = r[7:0];
            read_check(LPT_ADDR, "lpt data_bus_out_o", lpt_model, 1'b1);
        end
    endtask

    task automatic test_nmi_mask();
        logic [31:0] r;
        r = $random(seed);
        @(posedge clock);
        tandy_video <= 1'b0;
        io_write(NMI_ADDR + 20'(r[2:0]), r[15:8]);
        read_check(NMI_ADDR + 20'(r[5:3]), "nmi data_bus_out_o", 8'h00, 1'b0);
        @(posedge clock);
        tandy_video <= 1'b1;
        read_check(NMI_ADDR, "nmi data_bus_out_o", nmi_model, 1'b1);
        io_write(NMI_ADDR + 20'(r[2:0]), r[23:16]);
        nmi_model = r[23:16];
        read_check(NMI_ADDR + 20'(r[5:3]), "nmi data_bus_out_o", nmi_model, 1'b1);
        @(posedge clock);
        tandy_video <= 1'b0;
        read_check(NMI_ADDR, "nmi data_bus_out_o", 8'h00, 1'b0);
    endtask

    task automatic test_reset_values();
        @(posedge clock);
        reset       <= 1'b1;
        tandy_video <= 1'b1;
        address     <= {`PERIPH_EMS_FRAME_A, 16'h0123};
        ems_frame   <= 2'd0;
        repeat (5) @(posedge clock);
        reset <= 1'b0;
        lpt_model = 8'hFF;
        nmi_model = 8'hFF;
        ems_model = '0;
        repeat (3) begin
            @(negedge clock);
            check_value("data_bus_out_from_chipset_o", 32'(from_chipset), 32'd0);
            check_value("data_bus_out_o", 32'(data_bus_out), 32'd0);
            check_value("ems_map_o", 32'(ems_map), 32'd0);
            check_value("ems_bank_hit_o", 32'(ems_bank_hit), 32'd0);
        end
        read_check(LPT_ADDR, "lpt data_bus_out_o", 8'hFF, 1'b1);
        read_check(NMI_ADDR, "nmi data_bus_out_o", 8'hFF, 1'b1);
        for (int k = 0; k < 4; k++) begin
            read_check(EMS_ADDR + 20'(k), "ems data_bus_out_o", 8'hFF, 1'b1);
        end
    endtask

    task automatic finish_test(input int number, input string name, input int errors_before);
        if (error_count == errors_before) begin
            $display("test %0d (%s): passed", number, name);
        end else begin
            failed_tests++;
            $display("test %0d (%s): %0d errors", number, name, error_count - errors_before);
        end
    endtask

    initial begin
        int          errors_before;
        int unsigned assertion_failures;
        reset            = 1'b1;
        address          = '0;
        data             = '0;
        address_enable_n = 1'b1;
        io_read_n        = 1'b1;
        io_write_n       = 1'b1;
        ems_enabled      = 1'b1;
        tandy_video      = 1'b0;
        ems_frame        = '0;
        ems_model        = '0;
        lpt_model        = 8'hFF;
        nmi_model        = 8'hFF;
        repeat (5) @(posedge clock);
        reset <= 1'b0;

        errors_before = error_count;
        test_decode();
        finish_test(1, "chip-slot decode", errors_before);
        errors_before = error_count;
        test_ems_writes();
        finish_test(2, "EMS map, keep and unmap", errors_before);
        errors_before = error_count;
        test_bank_hits();
        finish_test(3, "EMS bank hits", errors_before);
        errors_before = error_count;
        test_printer();
        finish_test(4, "printer latch", errors_before);
        errors_before = error_count;
        test_nmi_mask();
        finish_test(5, "NMI mask", errors_before);
        errors_before = error_count;
        test_reset_values();
        finish_test(6, "reset values", errors_before);

        assertion_failures = peripherals_top_i.peripherals_properties_i.failure_count;
        $display("tests %0d, failed %0d, checks %0d, errors %0d, assertion failures %0d",
                 TEST_COUNT, failed_tests, check_count, error_count, assertion_failures);
        if (failed_tests == 0 && error_count == 0 && assertion_failures == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/peripherals_properties.sv
// Bus checks for the XT peripheral block
// Chip selects and the read-back flag

`default_nettype none
`timescale 1ns/1ps

module peripherals_properties (
    input logic                       clock,
    input logic                       reset,
    input io_map_pkg::chip_select_n_t chip_select_n_i,
    input logic                       io_read_n_i,
    input logic                       io_write_n_i,
    input logic                       read_valid_i
);

    int unsigned failure_count = 0;

    // Slot selects only during an I/O cycle
    a_select_needs_strobe: assert property (
        @(posedge clock) disable iff (reset)
        (chip_select_n_i != '1) |-> (!io_read_n_i || !io_write_n_i)
    ) else begin
        failure_count++;
        $error("chip select low without an I/O strobe");
    end

    a_flag_needs_read: assert property (
        @(posedge clock) disable iff (reset)
        io_read_n_i |=> !read_valid_i
    ) else begin
        failure_count++;
        $error("read-back flag high after a cycle without a read");
    end

endmodule

`default_nettype wire

// File: design/peripherals_top.sv
// XT peripheral block top level
// Address decode, chip-slot selects, EMS mapper, I/O latches
// and the registered CPU read-back bus

`default_nettype none
`timescale 1ns/1ps

module peripherals_top (
    input  logic                       clock,
    input  logic                       reset,
    input  io_map_pkg::bus_addr_t      address_i,
    input  io_map_pkg::bus_data_t      data_i,
    input  logic                       address_enable_n_i,
    input  logic                       io_read_n_i,
    input  logic                       io_write_n_i,
    input  logic                       ems_enabled_i,
    input  logic                       tandy_video_i,
    input  ems_pkg::ems_frame_sel_t    ems_frame_i,
    output io_map_pkg::chip_select_n_t chip_select_n_o,
    output logic [3:0]                 ems_bank_hit_o,
    output ems_pkg::ems_entry_t [3:0]  ems_map_o,
    output io_map_pkg::bus_data_t      data_bus_out_o,
    output logic                       data_bus_out_from_chipset_o
);

    import io_map_pkg::*;

    logic      ems_hit;
    logic      lpt_hit;
    logic      nmi_hit;
    logic      io_request;
    bus_data_t ems_read_data;
    bus_data_t lpt_data;
    bus_data_t nmi_mask;

    io_decoder io_decoder_i (
        .address_i          (address_i),
        .address_enable_n_i (address_enable_n_i),
        .io_read_n_i        (io_read_n_i),
        .io_write_n_i       (io_write_n_i),
        .ems_enabled_i      (ems_enabled_i),
        .tandy_video_i      (tandy_video_i),
        .chip_select_n_o    (chip_select_n_o),
        .ems_hit_o          (ems_hit),
        .lpt_hit_o          (lpt_hit),
        .nmi_hit_o          (nmi_hit),
        .io_request_o       (io_request)
    );

    ems_mapper ems_mapper_i (
        .clock        (clock),
        .reset        (reset),
        .ems_hit_i    (ems_hit),
        .io_write_n_i (io_write_n_i),
        .io_request_i (io_request),
        .address_i    (address_i),
        .data_i       (data_i),
        .ems_frame_i  (ems_frame_i),
        .read_data_o  (ems_read_data),
        .bank_hit_o   (ems_bank_hit_o),
        .map_o        (ems_map_o)
    );

    io_latches io_latches_i (
        .clock        (clock),
        .reset        (reset),
        .io_write_n_i (io_write_n_i),
        .lpt_hit_i    (lpt_hit),
        .nmi_hit_i    (nmi_hit),
        .data_i       (data_i),
        .lpt_data_o   (lpt_data),
        .nmi_mask_o   (nmi_mask)
    );

    readback_mux readback_mux_i (
        .clock                       (clock),
        .reset                       (reset),
        .io_read_n_i                 (io_read_n_i),
        .ems_hit_i                   (ems_hit),
        .lpt_hit_i                   (lpt_hit),
        .nmi_hit_i                   (nmi_hit),
        .ems_data_i                  (ems_read_data),
        .lpt_data_i                  (lpt_data),
        .nmi_data_i                  (nmi_mask),
        .data_bus_out_o              (data_bus_out_o),
        .data_bus_out_from_chipset_o (data_bus_out_from_chipset_o)
    );

endmodule

`default_nettype wire

// File: design/readback_mux.sv
// CPU read-back bus
// Registers the byte the chipset drives on an I/O read,
// chosen by fixed priority, together with its valid flag

`default_nettype none
`timescale 1ns/1ps

module readback_mux (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  io_read_n_i,
    input  logic                  ems_hit_i,
    input  logic                  lpt_hit_i,
    input  logic                  nmi_hit_i,
    input  io_map_pkg::bus_data_t ems_data_i,
    input  io_map_pkg::bus_data_t lpt_data_i,
    input  io_map_pkg::bus_data_t nmi_data_i,
    output io_map_pkg::bus_data_t data_bus_out_o,
    output logic                  data_bus_out_from_chipset_o
);

    import io_map_pkg::*;

    bus_data_t next_data;
    logic      next_valid;

    always_comb begin
        next_data  = '0;
        next_valid = 1'b0;
        if (!io_read_n_i) begin
            // EMS first, then printer, then NMI mask
            if (ems_hit_i) begin
                next_data  = ems_data_i;
                next_valid = 1'b1;
            end else if (lpt_hit_i) begin
                next_data  = lpt_data_i;
                next_valid = 1'b1;
            end else if (nmi_hit_i) begin
                next_data  = nmi_data_i;
                next_valid = 1'b1;
            end
        end
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            data_bus_out_o              <= '0;
            data_bus_out_from_chipset_o <= 1'b0;
        end else begin
            data_bus_out_o              <= next_data;
            data_bus_out_from_chipset_o <= next_valid;
        end
    end

endmodule

`default_nettype wire

// File: design/io_latches.sv
// CPU-written I/O registers
// Printer data latch and Tandy NMI mask, both read back by the CPU

`default_nettype none
`timescale 1ns/1ps

`include "peripherals_consts.svh"

module io_latches (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  io_write_n_i,
    input  logic                  lpt_hit_i,
    input  logic                  nmi_hit_i,
    input  io_map_pkg::bus_data_t data_i,
    output io_map_pkg::bus_data_t lpt_data_o,
    output io_map_pkg::bus_data_t nmi_mask_o
);

    logic lpt_load;
    logic nmi_load;

    assign lpt_load = lpt_hit_i & ~io_write_n_i;
    assign nmi_load = nmi_hit_i & ~io_write_n_i;

    // Printer port idles with all lines high
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            lpt_data_o <= `PERIPH_LPT_RESET;
        end else if (lpt_load) begin
            lpt_data_o <= data_i;
        end
    end

    // NMI mask, all bits set out of reset
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            nmi_mask_o <= `PERIPH_NMI_RESET;
        end else if (nmi_load) begin
            nmi_mask_o <= data_i;
        end
    end

endmodule

`default_nettype wire

// File: design/ems_mapper.sv
// EMS page mapper
// Four slot map registers behind a one-stage write pipeline,
// read-back of the addressed slot and bank hits for memory cycles

`default_nettype none
`timescale 1ns/1ps

`include "peripherals_consts.svh"

module ems_mapper (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       ems_hit_i,
    input  logic                       io_write_n_i,
    input  logic                       io_request_i,
    input  io_map_pkg::bus_addr_t      address_i,
    input  io_map_pkg::bus_data_t      data_i,
    input  ems_pkg::ems_frame_sel_t    ems_frame_i,
    output io_map_pkg::bus_data_t      read_data_o,
    output logic [3:0]                 bank_hit_o,
    output ems_pkg::ems_entry_t [3:0]  map_o
);

    import io_map_pkg::*;
    import ems_pkg::*;

    ems_entry_t [3:0] entries;
    ems_entry_t       read_entry;
    ems_slot_t        read_slot;
    logic             data_unmap;
    logic             data_map;
    logic             map_write;
    logic             write_valid;
    ems_slot_t        write_slot;
    ems_entry_t       write_entry;
    logic [3:0]       frame_top;

    // Data 0xFF unmaps, below 0x80 maps, anything else is ignored
    assign data_unmap = (data_i == `PERIPH_EMS_UNMAP);
    assign data_map   = (data_i < `PERIPH_EMS_LIMIT);
    assign map_write  = ems_hit_i & ~io_write_n_i & (data_unmap | data_map);

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            write_valid <= 1'b0;
        end else begin
            write_valid <= map_write;
        end
    end

    always_ff @(posedge clock) begin
        write_slot         <= address_i[1:0];
        write_entry.enable <= ~data_unmap;
        write_entry.page   <= data_unmap ? 7'h7F : data_i[6:0];
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            entries <= '0;
        end else if (write_valid) begin
            entries[write_slot] <= write_entry;
        end
    end

    // Read-back follows the live address
    assign read_slot   = address_i[1:0];
    assign read_entry  = entries[read_slot];
    assign read_data_o = read_entry.enable ? bus_data_t'({1'b0, read_entry.page}) : 8'hFF;

    always_comb begin
        case (ems_frame_i)
            2'd0:    frame_top = `PERIPH_EMS_FRAME_A;
            2'd1:    frame_top = `PERIPH_EMS_FRAME_C;
            default: frame_top = `PERIPH_EMS_FRAME_D;
        endcase
    end

    // Each slot covers 16 KB of the 64 KB frame
    for (genvar k = 0; k < 4; k++) begin : g_bank
        assign bank_hit_o[k] = ~io_request_i & entries[k].enable
                             & (address_i[19:14] == {frame_top, ems_slot_t'(k)});
    end

    assign map_o = entries;

endmodule

`default_nettype wire

// File: design/io_decoder.sv
// I/O address decoder
// Turns the bus address and strobes into chip-slot selects
// and the register hits of the EMS, printer and NMI ports

`default_nettype none
`timescale 1ns/1ps

`include "peripherals_consts.svh"

module io_decoder (
    input  io_map_pkg::bus_addr_t      address_i,
    input  logic                       address_enable_n_i,
    input  logic                       io_read_n_i,
    input  logic                       io_write_n_i,
    input  logic                       ems_enabled_i,
    input  logic                       tandy_video_i,
    output io_map_pkg::chip_select_n_t chip_select_n_o,
    output logic                       ems_hit_o,
    output logic                       lpt_hit_o,
    output logic                       nmi_hit_o,
    output logic                       io_request_o
);

    import io_map_pkg::*;

    io_port_t port;
    logic     io_strobe;
    logic     io_cycle;
    logic     slot_space;

    assign port      = address_i[15:0];
    assign io_strobe = ~io_read_n_i | ~io_write_n_i;

    // Address is valid for I/O only while AEN is low
    assign io_cycle = io_strobe & ~address_enable_n_i;

    // Slots live in the first 256 ports
    assign slot_space = io_cycle & (address_i[9:8] == 2'b00);

    always_comb begin
        chip_select_n_o = '1;
        if (slot_space && (address_i[7:5] <= slot_dma_page)) begin
            chip_select_n_o[address_i[7:5]] = 1'b0;
        end
    end

    // EMS block decodes four ports
    assign ems_hit_o = io_cycle & ems_enabled_i
                     & ({port[15:2], 2'b00} == `PERIPH_EMS_PORT_BASE);

    assign lpt_hit_o = io_cycle & (port == `PERIPH_LPT_PORT);

    // NMI mask exists only on Tandy video, eight aliases
    assign nmi_hit_o = io_cycle & tandy_video_i
                     & ({port[15:3], 3'b000} == `PERIPH_NMI_PORT_BASE);

    assign io_request_o = io_strobe;

endmodule

`default_nettype wire

// File: design/ems_pkg.sv
// EMS types
// Slot index, page number, map entry and page-frame choice

`default_nettype none

package ems_pkg;

    // One of four 16 KB windows in the page frame
    typedef logic [1:0] ems_slot_t;

    // Page number held by a slot
    typedef logic [6:0] ems_page_t;

    // Map entry as stored per slot
    typedef struct packed {
        logic      enable;
        ems_page_t page;
    } ems_entry_t;

    // 0 selects frame A, 1 frame C, anything else frame D
    typedef logic [1:0] ems_frame_sel_t;

endpackage

`default_nettype wire

// File: design/io_map_pkg.sv
// I/O map types
// CPU bus widths and the external chip-slot encoding

`default_nettype none

package io_map_pkg;

    // 20-bit CPU address and 8-bit data
    typedef logic [19:0] bus_addr_t;
    typedef logic [7:0]  bus_data_t;

    // Low 16 bits of the address during an I/O cycle
    typedef logic [15:0] io_port_t;

    // Slot code equals address bits 7:5
    typedef enum logic [2:0] {
        slot_dma      = 3'd0,
        slot_pic      = 3'd1,
        slot_pit      = 3'd2,
        slot_ppi      = 3'd3,
        slot_dma_page = 3'd4
    } chip_slot_t;

    // Active-low select, one bit per slot code
    typedef logic [4:0] chip_select_n_t;

endpackage

`default_nettype wire

// File: design/peripherals_consts.svh
// Peripheral block constants
// Port addresses, EMS page-frame tops and register reset values

`ifndef PERIPHERALS_CONSTS_SVH
`define PERIPHERALS_CONSTS_SVH

// EMS mapping registers, 0x260 to 0x263
`define PERIPH_EMS_PORT_BASE    16'h0260

// Printer data port
`define PERIPH_LPT_PORT         16'h0378

// Tandy NMI mask, 0xA0 to 0xA7
`define PERIPH_NMI_PORT_BASE    16'h00A0

// Address bits 19:16 of each EMS page frame
`define PERIPH_EMS_FRAME_A      4'hA
`define PERIPH_EMS_FRAME_C      4'hC
`define PERIPH_EMS_FRAME_D      4'hD

// Map register data rules
`define PERIPH_EMS_UNMAP        8'hFF
`define PERIPH_EMS_LIMIT        8'h80

// Register values after reset
`define PERIPH_LPT_RESET        8'hFF
`define PERIPH_NMI_RESET        8'hFF

`endif
